// ==== common/gb_alu_pkg.sv ====
`default_nettype none

package gb_alu_pkg;

    ////////////////////
    // Data widths
    ////////////////////

    typedef logic [7:0] byte_t;
    typedef logic [3:0] flags_t;
    typedef logic [2:0] reg_sel_t;
    typedef logic [2:0] bit_idx_t;
    typedef logic [4:0] alu_op_t;

    ////////////////////
    // ALU operations
    ////////////////////

    // Arithmetic and logic group, same order as opcode bits 5:3
    localparam alu_op_t OP_ADD  = 5'b00000;
    localparam alu_op_t OP_ADC  = 5'b00001;
    localparam alu_op_t OP_SUB  = 5'b00010;
    localparam alu_op_t OP_SBC  = 5'b00011;
    localparam alu_op_t OP_AND  = 5'b00100;
    localparam alu_op_t OP_XOR  = 5'b00101;
    localparam alu_op_t OP_OR   = 5'b00110;
    localparam alu_op_t OP_CP   = 5'b00111;

    // CB row ops, 8 plus the row number
    localparam alu_op_t OP_RLC  = 5'b01000;
    localparam alu_op_t OP_RRC  = 5'b01001;
    localparam alu_op_t OP_RL   = 5'b01010;
    localparam alu_op_t OP_RR   = 5'b01011;
    localparam alu_op_t OP_SLA  = 5'b01100;
    localparam alu_op_t OP_SRA  = 5'b01101;
    localparam alu_op_t OP_SWAP = 5'b01110;
    localparam alu_op_t OP_SRL  = 5'b01111;

    // Operand b straight through, flags kept
    localparam alu_op_t OP_PASS = 5'b10001;

    localparam alu_op_t OP_DAA  = 5'b10100;
    localparam alu_op_t OP_CPL  = 5'b10101;
    localparam alu_op_t OP_SCF  = 5'b10110;
    localparam alu_op_t OP_CCF  = 5'b10111;

    localparam alu_op_t OP_BIT  = 5'b11101;
    localparam alu_op_t OP_RES  = 5'b11110;
    localparam alu_op_t OP_SET  = 5'b11111;

    // Flag bit positions in F
    localparam int F_Z = 3;
    localparam int F_N = 2;
    localparam int F_H = 1;
    localparam int F_C = 0;

    ////////////////////
    // Register codes
    ////////////////////

    localparam reg_sel_t REG_B   = 3'd0;
    localparam reg_sel_t REG_C   = 3'd1;
    localparam reg_sel_t REG_D   = 3'd2;
    localparam reg_sel_t REG_E   = 3'd3;
    localparam reg_sel_t REG_H   = 3'd4;
    localparam reg_sel_t REG_L   = 3'd5;
    // Immediate byte in place of a register
    localparam reg_sel_t REG_IMM = 3'd6;
    localparam reg_sel_t REG_A   = 3'd7;

endpackage

`default_nettype wire

// ==== alu/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  gb_alu_pkg::byte_t    alu_a,
    input  gb_alu_pkg::byte_t    alu_b,
    input  gb_alu_pkg::bit_idx_t alu_bit_index,
    input  gb_alu_pkg::flags_t   alu_flags_in,
    input  gb_alu_pkg::alu_op_t  alu_op,
    output gb_alu_pkg::byte_t    alu_result,
    output gb_alu_pkg::flags_t   alu_flags_out
);

    import gb_alu_pkg::*;

    logic [4:0] sum_lo;
    logic [4:0] sum_hi;
    logic [8:0] daa_1;
    logic [8:0] daa_2;
    logic       carry_in;
    logic       shift_out;

    function automatic logic is_zero(byte_t value);
        return (value == 8'd0);
    endfunction

    always_comb begin
        sum_lo        = '0;
        sum_hi        = '0;
        daa_1         = '0;
        daa_2         = '0;
        carry_in      = 1'b0;
        shift_out     = 1'b0;
        alu_result    = alu_b;
        alu_flags_out = alu_flags_in;

        case (alu_op)
            ////////////////////
            // Nibble-wise add
            ////////////////////
            OP_ADD, OP_ADC: begin
                carry_in = (alu_op == OP_ADC) ? alu_flags_in[F_C] : 1'b0;
                sum_lo = {1'b0, alu_a[3:0]} + {1'b0, alu_b[3:0]} + {4'b0, carry_in};
                sum_hi = {1'b0, alu_a[7:4]} + {1'b0, alu_b[7:4]} + {4'b0, sum_lo[4]};
                alu_result = {sum_hi[3:0], sum_lo[3:0]};
                alu_flags_out[F_Z] = is_zero(alu_result);
                alu_flags_out[F_N] = 1'b0;
                alu_flags_out[F_H] = sum_lo[4];
                alu_flags_out[F_C] = sum_hi[4];
            end

            // Bit 4 of each nibble difference is the borrow
            OP_SUB, OP_SBC, OP_CP: begin
                carry_in = (alu_op == OP_SBC) ? alu_flags_in[F_C] : 1'b0;
                sum_lo = {1'b0, alu_a[3:0]} - {1'b0, alu_b[3:0]} - {4'b0, carry_in};
                sum_hi = {1'b0, alu_a[7:4]} - {1'b0, alu_b[7:4]} - {4'b0, sum_lo[4]};
                alu_result = {sum_hi[3:0], sum_lo[3:0]};
                alu_flags_out[F_Z] = is_zero(alu_result);
                alu_flags_out[F_N] = 1'b1;
                alu_flags_out[F_H] = sum_lo[4];
                alu_flags_out[F_C] = sum_hi[4];
            end

            OP_AND: begin
                alu_result = alu_a & alu_b;
                alu_flags_out = 4'b0010;
                alu_flags_out[F_Z] = is_zero(alu_result);
            end

            OP_XOR: begin
                alu_result = alu_a ^ alu_b;
                alu_flags_out = 4'b0000;
                alu_flags_out[F_Z] = is_zero(alu_result);
            end

            OP_OR: begin
                alu_result = alu_a | alu_b;
                alu_flags_out = 4'b0000;
                alu_flags_out[F_Z] = is_zero(alu_result);
            end

            ////////////////////
            // BCD correction
            ////////////////////
            OP_DAA: begin
                if (!alu_flags_in[F_N]) begin
                    // After an add
                    if (alu_flags_in[F_H] || (alu_a[3:0] > 4'h9)) begin
                        daa_1 = {1'b0, alu_a} + 9'h006;
                    end else begin
                        daa_1 = {1'b0, alu_a};
                    end
                    if (alu_flags_in[F_C] || (daa_1 > 9'h09f)) begin
                        daa_2 = daa_1 + 9'h060;
                    end else begin
                        daa_2 = daa_1;
                    end
                end else begin
                    // After a subtract
                    if (alu_flags_in[F_H]) begin
                        daa_1 = {1'b0, alu_a - 8'h06};
                    end else begin
                        daa_1 = {1'b0, alu_a};
                    end
                    if (alu_flags_in[F_C]) begin
                        daa_2 = daa_1 - 9'h060;
                    end else begin
                        daa_2 = daa_1;
                    end
                end
                alu_result = daa_2[7:0];
                alu_flags_out[F_Z] = is_zero(daa_2[7:0]);
                alu_flags_out[F_N] = alu_flags_in[F_N];
                alu_flags_out[F_H] = 1'b0;
                alu_flags_out[F_C] = daa_2[8] | alu_flags_in[F_C];
            end

            OP_CPL: begin
                alu_result = ~alu_a;
                alu_flags_out[F_N] = 1'b1;
                alu_flags_out[F_H] = 1'b1;
            end

            OP_SCF, OP_CCF: begin
                alu_result = alu_b;
                alu_flags_out[F_N] = 1'b0;
                alu_flags_out[F_H] = 1'b0;
                alu_flags_out[F_C] = (alu_op == OP_SCF) ? 1'b1 : ~alu_flags_in[F_C];
            end

            ////////////////////
            // CB rotates and shifts
            ////////////////////
            OP_RLC, OP_RRC, OP_RL, OP_RR, OP_SLA, OP_SRA, OP_SRL: begin
                case (alu_op)
                    OP_RLC:  alu_result = {alu_a[6:0], alu_a[7]};
                    OP_RRC:  alu_result = {alu_a[0], alu_a[7:1]};
                    OP_RL:   alu_result = {alu_a[6:0], alu_flags_in[F_C]};
                    OP_RR:   alu_result = {alu_flags_in[F_C], alu_a[7:1]};
                    OP_SLA:  alu_result = {alu_a[6:0], 1'b0};
                    OP_SRA:  alu_result = {alu_a[7], alu_a[7:1]};
                    default: alu_result = {1'b0, alu_a[7:1]};
                endcase
                // Left moves bit 7 out, right moves bit 0 out
                shift_out = (alu_op == OP_RLC || alu_op == OP_RL || alu_op == OP_SLA) ?
                            alu_a[7] : alu_a[0];
                alu_flags_out[F_Z] = is_zero(alu_result);
                alu_flags_out[F_N] = 1'b0;
                alu_flags_out[F_H] = 1'b0;
                alu_flags_out[F_C] = shift_out;
            end

            OP_SWAP: begin
                alu_result = {alu_a[3:0], alu_a[7:4]};
                alu_flags_out = 4'b0000;
                alu_flags_out[F_Z] = is_zero(alu_result);
            end

            // Test only, register value passes through on b
            OP_BIT: begin
                alu_result = alu_b;
                alu_flags_out[F_Z] = ~alu_a[alu_bit_index];
                alu_flags_out[F_N] = 1'b0;
                alu_flags_out[F_H] = 1'b1;
            end

            OP_SET: begin
                alu_result = alu_a;
                alu_result[alu_bit_index] = 1'b1;
            end

            OP_RES: begin
                alu_result = alu_a;
                alu_result[alu_bit_index] = 1'b0;
            end

            // OP_PASS and unused codes keep the defaults
            default: begin
                alu_result = alu_b;
                alu_flags_out = alu_flags_in;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== alu/alu_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_decoder (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 instr_valid,
    input  logic                 instr_cb,
    input  gb_alu_pkg::byte_t    instr_opcode,
    input  gb_alu_pkg::byte_t    instr_imm,
    output logic                 ex_valid,
    output gb_alu_pkg::alu_op_t  ex_op,
    output gb_alu_pkg::reg_sel_t ex_a_sel,
    output gb_alu_pkg::reg_sel_t ex_b_sel,
    output gb_alu_pkg::reg_sel_t ex_dest_sel,
    output logic                 ex_write,
    output gb_alu_pkg::bit_idx_t ex_bit_index,
    output gb_alu_pkg::byte_t    ex_imm
);

    import gb_alu_pkg::*;

    logic     dec_ok;
    alu_op_t  dec_op;
    reg_sel_t dec_a_sel;
    reg_sel_t dec_b_sel;
    reg_sel_t dec_dest_sel;
    logic     dec_write;
    bit_idx_t dec_bit_index;
    logic     imm_form;

    // Register field of the opcode, code 6 is an (HL) form
    reg_sel_t opc_reg;
    assign opc_reg  = instr_opcode[2:0];
    assign imm_form = (instr_opcode[7:6] == 2'b11) && (instr_opcode[2:0] == 3'b110);

    ////////////////////
    // Opcode decode
    ////////////////////
    always_comb begin
        dec_ok        = 1'b0;
        dec_op        = OP_PASS;
        dec_a_sel     = REG_A;
        dec_b_sel     = REG_A;
        dec_dest_sel  = REG_A;
        dec_write     = 1'b0;
        dec_bit_index = '0;

        if (instr_cb) begin
            dec_ok        = (opc_reg != REG_IMM);
            dec_a_sel     = opc_reg;
            dec_b_sel     = opc_reg;
            dec_dest_sel  = opc_reg;
            dec_bit_index = instr_opcode[5:3];
            case (instr_opcode[7:6])
                2'b00: begin
                    dec_op    = {2'b01, instr_opcode[5:3]};
                    dec_write = 1'b1;
                end
                2'b01: begin
                    dec_op    = OP_BIT;
                    dec_write = 1'b0;
                end
                2'b10: begin
                    dec_op    = OP_RES;
                    dec_write = 1'b1;
                end
                default: begin
                    dec_op    = OP_SET;
                    dec_write = 1'b1;
                end
            endcase
        end else if (instr_opcode[7:6] == 2'b10 || imm_form) begin
            // ALU group on A, CP only sets flags
            dec_op    = {2'b00, instr_opcode[5:3]};
            dec_b_sel = imm_form ? REG_IMM : opc_reg;
            dec_ok    = imm_form || (opc_reg != REG_IMM);
            dec_write = (dec_op != OP_CP);
        end else if (instr_opcode[7:6] == 2'b00 && instr_opcode[2:0] == 3'b110 &&
                     instr_opcode[5:3] != REG_IMM) begin
            // LD r,n
            dec_ok       = 1'b1;
            dec_op       = OP_PASS;
            dec_b_sel    = REG_IMM;
            dec_dest_sel = instr_opcode[5:3];
            dec_write    = 1'b1;
        end else begin
            case (instr_opcode)
                8'h27: dec_op = OP_DAA;
                8'h2f: dec_op = OP_CPL;
                8'h37: dec_op = OP_SCF;
                8'h3f: dec_op = OP_CCF;
                default: dec_op = OP_PASS;
            endcase
            dec_ok    = (instr_opcode == 8'h27) || (instr_opcode == 8'h2f) ||
                        (instr_opcode == 8'h37) || (instr_opcode == 8'h3f);
            dec_write = dec_ok;
        end
    end

    // Execute stage registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid     <= 1'b0;
            ex_op        <= OP_ADD;
            ex_a_sel     <= REG_B;
            ex_b_sel     <= REG_B;
            ex_dest_sel  <= REG_B;
            ex_write     <= 1'b0;
            ex_bit_index <= '0;
            ex_imm       <= '0;
        end else begin
            ex_valid <= instr_valid && dec_ok;
            if (instr_valid) begin
                ex_op        <= dec_op;
                ex_a_sel     <= dec_a_sel;
                ex_b_sel     <= dec_b_sel;
                ex_dest_sel  <= dec_dest_sel;
                ex_write     <= dec_write;
                ex_bit_index <= dec_bit_index;
                ex_imm       <= instr_imm;
            end
        end
    end

    // Immediate code never reaches the register file as a destination
    a_no_imm_dest: assert property (@(posedge clk) disable iff (!arst_n)
        (ex_valid && ex_write) |-> (ex_dest_sel != REG_IMM));

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 ex_valid,
    input  logic                 ex_write,
    input  gb_alu_pkg::reg_sel_t ex_a_sel,
    input  gb_alu_pkg::reg_sel_t ex_b_sel,
    input  gb_alu_pkg::reg_sel_t ex_dest_sel,
    input  gb_alu_pkg::byte_t    ex_imm,
    input  gb_alu_pkg::byte_t    alu_result,
    input  gb_alu_pkg::flags_t   alu_flags,
    output gb_alu_pkg::byte_t    opnd_a,
    output gb_alu_pkg::byte_t    opnd_b,
    output gb_alu_pkg::flags_t   flags_cur,
    output logic                 res_valid,
    output logic                 res_write,
    output gb_alu_pkg::reg_sel_t res_dest,
    output gb_alu_pkg::byte_t    res_data,
    output gb_alu_pkg::flags_t   res_flags
);

    import gb_alu_pkg::*;

    // Indexed by register code with slot 6 unused
    byte_t  regs [8];
    flags_t flag_r;

    // Immediate code reads the instruction byte
    assign opnd_a    = (ex_a_sel == REG_IMM) ? ex_imm : regs[ex_a_sel];
    assign opnd_b    = (ex_b_sel == REG_IMM) ? ex_imm : regs[ex_b_sel];
    assign flags_cur = flag_r;

    ////////////////////
    // Writeback and report
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            flag_r    <= '0;
            res_valid <= 1'b0;
            res_write <= 1'b0;
            res_dest  <= REG_B;
            res_data  <= '0;
            res_flags <= '0;
        end else begin
            res_valid <= ex_valid;
            if (ex_valid) begin
                if (ex_write) begin
                    regs[ex_dest_sel] <= alu_result;
                end
                // F is written by every instruction
                flag_r    <= alu_flags;
                res_write <= ex_write;
                res_dest  <= ex_dest_sel;
                res_data  <= alu_result;
                res_flags <= alu_flags;
            end
        end
    end

    // Immediate slot is never a writeback target
    a_imm_slot_clear: assert property (@(posedge clk) disable iff (!arst_n)
        regs[REG_IMM] == 8'h00);

endmodule

`default_nettype wire

// ==== hdl/alu_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_exec_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 instr_valid,
    input  gb_alu_pkg::byte_t    instr_opcode,
    input  logic                 instr_cb,
    input  gb_alu_pkg::byte_t    instr_imm,
    output logic                 res_valid,
    output gb_alu_pkg::reg_sel_t res_dest,
    output logic                 res_write,
    output gb_alu_pkg::byte_t    res_data,
    output gb_alu_pkg::flags_t   res_flags
);

    import gb_alu_pkg::*;

    // Execute stage
    logic     ex_valid;
    alu_op_t  ex_op;
    reg_sel_t ex_a_sel;
    reg_sel_t ex_b_sel;
    reg_sel_t ex_dest_sel;
    logic     ex_write;
    bit_idx_t ex_bit_index;
    byte_t    ex_imm;

    // Operands and ALU outputs
    byte_t    opnd_a;
    byte_t    opnd_b;
    flags_t   flags_cur;
    byte_t    alu_result;
    flags_t   alu_flags;

    alu_decoder u_decoder (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr_cb     (instr_cb),
        .instr_opcode (instr_opcode),
        .instr_imm    (instr_imm),
        .ex_valid     (ex_valid),
        .ex_op        (ex_op),
        .ex_a_sel     (ex_a_sel),
        .ex_b_sel     (ex_b_sel),
        .ex_dest_sel  (ex_dest_sel),
        .ex_write     (ex_write),
        .ex_bit_index (ex_bit_index),
        .ex_imm       (ex_imm)
    );

    reg_file u_reg_file (
        .clk         (clk),
        .arst_n      (arst_n),
        .ex_valid    (ex_valid),
        .ex_write    (ex_write),
        .ex_a_sel    (ex_a_sel),
        .ex_b_sel    (ex_b_sel),
        .ex_dest_sel (ex_dest_sel),
        .ex_imm      (ex_imm),
        .alu_result  (alu_result),
        .alu_flags   (alu_flags),
        .opnd_a      (opnd_a),
        .opnd_b      (opnd_b),
        .flags_cur   (flags_cur),
        .res_valid   (res_valid),
        .res_write   (res_write),
        .res_dest    (res_dest),
        .res_data    (res_data),
        .res_flags   (res_flags)
    );

    alu u_alu (
        .alu_a         (opnd_a),
        .alu_b         (opnd_b),
        .alu_bit_index (ex_bit_index),
        .alu_flags_in  (flags_cur),
        .alu_op        (ex_op),
        .alu_result    (alu_result),
        .alu_flags_out (alu_flags)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic arst_n
);

    localparam time HALF_PERIOD = 10ns;
    localparam int  RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset released on a rising edge after three cycles
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/alu_exec_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_exec_checker (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 instr_valid,
    input  gb_alu_pkg::byte_t    instr_opcode,
    input  logic                 instr_cb,
    input  gb_alu_pkg::byte_t    instr_imm,
    input  logic                 res_valid,
    input  gb_alu_pkg::reg_sel_t res_dest,
    input  logic                 res_write,
    input  gb_alu_pkg::byte_t    res_data,
    input  gb_alu_pkg::flags_t   res_flags,
    output int                   error_count,
    output int                   check_count,
    output logic                 pending
);

    import gb_alu_pkg::*;

    // Model state with slot 6 unused
    byte_t    model_regs [8];
    flags_t   model_f;

    // Two-stage queue of expected reports
    logic     s1_valid;
    logic     s1_write;
    reg_sel_t s1_dest;
    byte_t    s1_data;
    flags_t   s1_flags;
    logic [8:0] s1_instr;
    logic     s2_valid;
    logic     s2_write;
    reg_sel_t s2_dest;
    byte_t    s2_data;
    flags_t   s2_flags;
    logic [8:0] s2_instr;

    assign pending = s1_valid || s2_valid;

    initial begin
        error_count = 0;
        check_count = 0;
        s1_valid    = 1'b0;
        s2_valid    = 1'b0;
    end

    function automatic flags_t make_flags(logic z, logic n, logic h, logic c);
        flags_t f;
        f      = '0;
        f[F_Z] = z;
        f[F_N] = n;
        f[F_H] = h;
        f[F_C] = c;
        return f;
    endfunction

    task automatic check_field(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s: got 0x%h, expected 0x%h (cb %b opcode 0x%h)",
                     name, got, exp, s2_instr[8], s2_instr[7:0]);
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    task automatic model_step(input logic cb, input byte_t opc, input byte_t imm);
        reg_sel_t rs;
        byte_t    a;
        byte_t    v;
        byte_t    r;
        flags_t   f;
        logic     ok;
        logic     wr;
        reg_sel_t dst;
        logic     cin;
        int       full;
        int       lo;

        rs  = opc[2:0];
        a   = model_regs[REG_A];
        v   = (rs == REG_IMM) ? imm : model_regs[rs];
        f   = model_f;
        r   = 8'h00;
        ok  = 1'b0;
        wr  = 1'b1;
        dst = REG_A;

        if (cb) begin
            ok  = (rs != REG_IMM);
            dst = rs;
            case (opc[7:6])
                2'b00: begin
                    case (opc[5:3])
                        3'd0: r = {v[6:0], v[7]};
                        3'd1: r = {v[0], v[7:1]};
                        3'd2: r = {v[6:0], f[F_C]};
                        3'd3: r = {f[F_C], v[7:1]};
                        3'd4: r = {v[6:0], 1'b0};
                        3'd5: r = {v[7], v[7:1]};
                        3'd6: r = {v[3:0], v[7:4]};
                        default: r = {1'b0, v[7:1]};
                    endcase
                    // Carry takes the bit shifted out
                    case (opc[5:3])
                        3'd0, 3'd2, 3'd4: f[F_C] = v[7];
                        3'd6:             f[F_C] = 1'b0;
                        default:          f[F_C] = v[0];
                    endcase
                    f[F_Z] = (r == 8'h00);
                    f[F_N] = 1'b0;
                    f[F_H] = 1'b0;
                end
                2'b01: begin
                    // BIT reports the register unchanged
                    r      = v;
                    wr     = 1'b0;
                    f[F_Z] = ~v[opc[5:3]];
                    f[F_N] = 1'b0;
                    f[F_H] = 1'b1;
                end
                2'b10: r = v & ~(8'h01 << opc[5:3]);
                default: r = v | (8'h01 << opc[5:3]);
            endcase
        end else if (opc[7:6] == 2'b10 || (opc[7:6] == 2'b11 && rs == REG_IMM)) begin
            ok  = (opc[7:6] == 2'b11) || (rs != REG_IMM);
            cin = opc[3] && !opc[5] && f[F_C];
            case (opc[5:3])
                3'd0, 3'd1: begin
                    full = a + v + cin;
                    lo   = a[3:0] + v[3:0] + cin;
                    r    = byte_t'(full);
                    f    = make_flags(r == 8'h00, 1'b0, lo > 15, full > 255);
                end
                3'd4: begin
                    r = a & v;
                    f = make_flags(r == 8'h00, 1'b0, 1'b1, 1'b0);
                end
                3'd5: begin
                    r = a ^ v;
                    f = make_flags(r == 8'h00, 1'b0, 1'b0, 1'b0);
                end
                3'd6: begin
                    r = a | v;
                    f = make_flags(r == 8'h00, 1'b0, 1'b0, 1'b0);
                end
                default: begin
                    // SUB, SBC and CP borrow from bit 4 and bit 8
                    full = a - v - cin;
                    lo   = a[3:0] - v[3:0] - cin;
                    r    = byte_t'(full);
                    f    = make_flags(r == 8'h00, 1'b1, lo < 0, full < 0);
                end
            endcase
            wr = (opc[5:3] != 3'd7);
        end else if (opc[7:6] == 2'b00 && rs == REG_IMM && opc[5:3] != REG_IMM) begin
            ok  = 1'b1;
            r   = imm;
            dst = opc[5:3];
        end else begin
            ok = 1'b1;
            r  = a;
            case (opc)
                8'h27: begin
                    if (!f[F_N]) begin
                        if (f[F_C] || a > 8'h99) begin
                            r      = r + 8'h60;
                            f[F_C] = 1'b1;
                        end
                        if (f[F_H] || a[3:0] > 4'h9) begin
                            r = r + 8'h06;
                        end
                    end else begin
                        if (f[F_C]) begin
                            r = r - 8'h60;
                        end
                        if (f[F_H]) begin
                            r = r - 8'h06;
                        end
                    end
                    f[F_Z] = (r == 8'h00);
                    f[F_H] = 1'b0;
                end
                8'h2f: begin
                    r      = ~a;
                    f[F_N] = 1'b1;
                    f[F_H] = 1'b1;
                end
                8'h37: f = make_flags(f[F_Z], 1'b0, 1'b0, 1'b1);
                8'h3f: f = make_flags(f[F_Z], 1'b0, 1'b0, ~f[F_C]);
                default: ok = 1'b0;
            endcase
        end

        if (ok) begin
            if (wr) begin
                model_regs[dst] = r;
            end
            model_f = f;
        end
        s1_valid = ok;
        s1_write = wr;
        s1_dest  = dst;
        s1_data  = r;
        s1_flags = f;
        s1_instr = {cb, opc};
    endtask

    ////////////////////
    // Compare and advance
    ////////////////////
    always @(posedge clk) begin
        if (!arst_n) begin
            if (res_valid !== 1'b0) begin
                error_count++;
                $display("res_valid is not low while reset is asserted");
            end
            for (int i = 0; i < 8; i++) begin
                model_regs[i] = 8'h00;
            end
            model_f  = '0;
            s1_valid = 1'b0;
            s2_valid = 1'b0;
        end else begin
            if (s2_valid && res_valid !== 1'b1) begin
                error_count++;
                $display("No result reported for cb %b opcode 0x%h",
                         s2_instr[8], s2_instr[7:0]);
            end else if (!s2_valid && res_valid !== 1'b0) begin
                error_count++;
                $display("Result reported with no supported instruction before it");
            end else if (s2_valid) begin
                check_count++;
                check_field("res_dest", 8'(res_dest), 8'(s2_dest));
                check_field("res_write", 8'(res_write), 8'(s2_write));
                check_field("res_data", res_data, s2_data);
                check_field("res_flags", 8'(res_flags), 8'(s2_flags));
            end

            s2_valid = s1_valid;
            s2_write = s1_write;
            s2_dest  = s1_dest;
            s2_data  = s1_data;
            s2_flags = s1_flags;
            s2_instr = s1_instr;
            s1_valid = 1'b0;
            if (instr_valid) begin
                model_step(instr_cb, instr_opcode, instr_imm);
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_alu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_alu_exec;

    import gb_alu_pkg::*;

    localparam logic [31:0] SEED          = 32'h878d8af7;
    localparam int          N_RANDOM      = 400;
    localparam int          RESET_TIMEOUT = 10;
    localparam int          FINAL_TIMEOUT = 20;

    logic     clk;
    logic     arst_n;
    logic     instr_valid;
    byte_t    instr_opcode;
    logic     instr_cb;
    byte_t    instr_imm;
    logic     res_valid;
    reg_sel_t res_dest;
    logic     res_write;
    byte_t    res_data;
    flags_t   res_flags;
    int       check_errors;
    int       check_count;
    logic     pending;
    int       tb_errors;

    tb_clock u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    alu_exec_top uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr_opcode (instr_opcode),
        .instr_cb     (instr_cb),
        .instr_imm    (instr_imm),
        .res_valid    (res_valid),
        .res_dest     (res_dest),
        .res_write    (res_write),
        .res_data     (res_data),
        .res_flags    (res_flags)
    );

    alu_exec_checker u_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr_opcode (instr_opcode),
        .instr_cb     (instr_cb),
        .instr_imm    (instr_imm),
        .res_valid    (res_valid),
        .res_dest     (res_dest),
        .res_write    (res_write),
        .res_data     (res_data),
        .res_flags    (res_flags),
        .error_count  (check_errors),
        .check_count  (check_count),
        .pending      (pending)
    );

    task automatic send_instr(input logic cb, input byte_t opc, input byte_t imm);
        @(posedge clk);
        instr_valid  <= 1'b1;
        instr_cb     <= cb;
        instr_opcode <= opc;
        instr_imm    <= imm;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    // Any register code except the immediate slot
    function automatic reg_sel_t pick_reg();
        reg_sel_t r;
        r = reg_sel_t'($urandom_range(0, 6));
        if (r == REG_IMM) begin
            r = REG_A;
        end
        return r;
    endfunction

    ////////////////////
    // Random instruction mix
    ////////////////////
    task automatic send_random();
        int         kind;
        byte_t      imm;
        logic [2:0] sel;

        kind = $urandom_range(0, 9);
        imm  = byte_t'($urandom);
        sel  = 3'($urandom_range(0, 7));
        case (kind)
            0, 1, 2: send_instr(1'b0, {2'b10, sel, pick_reg()}, imm);
            3: send_instr(1'b0, {2'b11, sel, 3'b110}, imm);
            4: send_instr(1'b1, {2'b00, sel, pick_reg()}, imm);
            5: send_instr(1'b1, {2'($urandom_range(1, 3)), sel, pick_reg()}, imm);
            6: begin
                // ADD or SUB immediate followed by DAA
                send_instr(1'b0, $urandom_range(0, 1) ? 8'hd6 : 8'hc6, imm);
                send_instr(1'b0, 8'h27, 8'h00);
            end
            7: begin
                case ($urandom_range(0, 3))
                    0: send_instr(1'b0, 8'h27, imm);
                    1: send_instr(1'b0, 8'h2f, imm);
                    2: send_instr(1'b0, 8'h37, imm);
                    default: send_instr(1'b0, 8'h3f, imm);
                endcase
            end
            8: send_instr(1'b0, {2'b00, pick_reg(), 3'b110}, imm);
            default: begin
                // (HL) forms and opcodes outside the set
                case ($urandom_range(0, 4))
                    0: send_instr(1'b0, {2'b10, sel, 3'b110}, imm);
                    1: send_instr(1'b1, {2'($urandom_range(0, 3)), sel, 3'b110}, imm);
                    2: send_instr(1'b0, 8'h00, imm);
                    3: send_instr(1'b0, 8'h36, imm);
                    default: send_instr(1'b0, {2'b01, pick_reg(), pick_reg()}, imm);
                endcase
            end
        endcase
    endtask

    initial begin
        int    waited;
        int    seed_ret;
        byte_t ld_val;

        instr_valid  = 1'b0;
        instr_opcode = 8'h00;
        instr_cb     = 1'b0;
        instr_imm    = 8'h00;
        tb_errors    = 0;

        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!arst_n && waited < RESET_TIMEOUT);

        if (!arst_n) begin
            tb_errors++;
            $display("Reset was never released");
        end else begin
            seed_ret = $urandom(SEED);

            // OR A,r on every register shows the reset values
            for (int r = 0; r < 8; r++) begin
                if (r != REG_IMM) begin
                    send_instr(1'b0, byte_t'(8'hb0 | r), 8'h00);
                end
            end
            // Preload with LD r,n
            for (int r = 0; r < 8; r++) begin
                if (r != REG_IMM) begin
                    ld_val = byte_t'($urandom);
                    send_instr(1'b0, {2'b00, r[2:0], 3'b110}, ld_val);
                end
            end

            for (int n = 0; n < N_RANDOM; n++) begin
                send_random();
                if ($urandom_range(0, 3) == 0) begin
                    idle($urandom_range(1, 3));
                end
            end
            idle(2);

            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (pending && waited < FINAL_TIMEOUT);
            if (pending) begin
                tb_errors++;
                $display("Timed out waiting for the last result");
            end
        end

        $display("Results checked: %0d, checker errors: %0d, testbench errors: %0d",
                 check_count, check_errors, tb_errors);
        if (check_errors == 0 && tb_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
common/gb_alu_pkg.sv
alu/alu.sv
alu/alu_decoder.sv
hdl/reg_file.sv
hdl/alu_exec_top.sv
sim/tb_clock.sv
sim/alu_exec_checker.sv
sim/tb_alu_exec.sv
